// File: build.f
source/fetch_pkg.sv
source/pc_gen.sv
source/imem_fetch_port.sv
source/priv_predecode.sv
source/priv_serializer.sv
source/fetch_skid_reg.sv
source/fetch_top.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the fetch testbench with Verilator, verdict from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module fetch_tb -f build.f -o fetch_sim \
    && ./obj_dir/fetch_sim | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -qx "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: sim/fetch_tb.sv
`default_nettype none

module fetch_tb;

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic [31:0] flush_pc;
    logic        mem_ack;
    logic [31:0] mem_rdata0;
    logic [31:0] mem_rdata1;
    logic        dec_ready;
    logic        priv_at_ex;
    logic        cache_idle;
    logic        csr_done;
    logic        tlb_done;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        dec_valid;
    logic [31:0] dec_pc;
    logic [31:0] dec_inst0;
    logic [31:0] dec_inst1;

    logic [31:0] rng;
    int          cycle_cnt;
    int          cycle_limit;
    int          errors;
    int          test_err;
    int          groups;
    int          serialized;
    logic [31:0] exp_pc;
    logic        priv_en;      // memory may hold privileged words
    logic        test_priv;    // becomes priv_en at the next flush
    logic        bp_en;
    logic        flush_en;
    logic        flush_req;
    logic [31:0] flush_target;
    int          mr_state;     // 0 idle, 1 ack delay, 2 acked, 3 release delay
    int          mr_cnt;
    logic [31:0] mr_addr;
    logic        prev_req;
    logic [31:0] prev_addr;
    int          ser_phase;    // 0 none, 1 before priv_at_ex, 2 before completion
    int          ser_kind;
    int          ser_cnt;
    logic        blocked;      // fetch must stay stopped

    fetch_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .mem_ack    (mem_ack),
        .mem_rdata0 (mem_rdata0),
        .mem_rdata1 (mem_rdata1),
        .dec_ready  (dec_ready),
        .priv_at_ex (priv_at_ex),
        .cache_idle (cache_idle),
        .csr_done   (csr_done),
        .tlb_done   (tlb_done),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_pc),
        .dec_inst0  (dec_inst0),
        .dec_inst1  (dec_inst1)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // memory contents, a hash of the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr, input logic pen);
        logic [31:0] h;
        h = xorshift(addr ^ 32'h9e37_79b9);
        h = xorshift(h ^ {addr[15:0], addr[31:16]});
        if (pen && h[2:0] == 3'd0) begin
            case (h[4:3])
                2'd0:    return {fetch_pkg::OP_IBAR, h[21:0]};
                2'd1:    return {fetch_pkg::OP_CSR, h[21:0]};
                default: return {fetch_pkg::OP_TLB, h[21:0]};
            endcase
        end
        return {1'b1, h[30:0]};  // bit 31 set, never a privileged opcode
    endfunction

    // 0 ordinary, 1 barrier, 2 csr, 3 tlb
    function automatic int kind_of(input logic [31:0] w);
        if (w[31:22] == fetch_pkg::OP_IBAR) return 1;
        if (w[31:22] == fetch_pkg::OP_CSR) return 2;
        if (w[31:22] == fetch_pkg::OP_TLB) return 3;
        return 0;
    endfunction

    task automatic note_error();
        errors++;
        test_err++;
    endtask

    // sampled at the falling edge, outputs and inputs are both settled
    task automatic check_cycle();
        logic [31:0] w0;
        logic [31:0] w1;
        int          k;
        if (mem_req && !prev_req) begin
            assert (!mem_ack) else begin
                $display("Error %0t: mem_req rose while mem_ack was still high", $time);
                note_error();
            end
            assert (!blocked) else begin
                $display("Error %0t: fetch restarted before completion, kind %0d",
                         $time, ser_kind);
                note_error();
            end
        end
        if (mem_req && prev_req) begin
            assert (mem_addr == prev_addr) else begin
                $display("Error %0t: mem_addr moved from %h to %h during a request",
                         $time, prev_addr, mem_addr);
                note_error();
            end
        end
        prev_req  = mem_req;
        prev_addr = mem_addr;
        if (dec_valid && dec_ready) begin
            w0 = mem_word(exp_pc, priv_en);
            w1 = (kind_of(w0) != 0) ? fetch_pkg::INST_NOP : mem_word(exp_pc + 32'd4, priv_en);
            assert (dec_pc == exp_pc && dec_inst0 == w0 && dec_inst1 == w1) else begin
                $display("Error %0t: decode got %h %h %h, expected %h %h %h", $time,
                         dec_pc, dec_inst0, dec_inst1, exp_pc, w0, w1);
                note_error();
            end
            k = (kind_of(w0) != 0) ? kind_of(w0) : kind_of(w1);
            if (k != 0) begin
                ser_phase = 1;
                ser_kind  = k;
                ser_cnt   = next_rand() % 8;
                blocked   = 1'b1;
                serialized++;
            end
            exp_pc = exp_pc + ((kind_of(w0) != 0) ? 32'd4 : 32'd8);
            groups++;
        end
        if (flush) begin  // after the handshake, that group still counts
            exp_pc    = flush_pc;
            ser_phase = 0;
            blocked   = 1'b0;
            priv_en   = test_priv;
        end
        if (mr_state == 0 && mem_req) begin
            mr_state = 1;
            mr_cnt   = next_rand() % 4;
            mr_addr  = mem_addr;
        end else if (mr_state == 2 && !mem_req) begin
            mr_state = 3;
            mr_cnt   = next_rand() % 4;
        end
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        dec_ready  = bp_en ? ((next_rand() % 4) != 0) : 1'b1;
        flush      = 1'b0;
        priv_at_ex = 1'b0;
        cache_idle = 1'b0;
        csr_done   = 1'b0;
        tlb_done   = 1'b0;
        r = next_rand();
        if (flush_req) begin
            flush     = 1'b1;
            flush_pc  = flush_target;
            flush_req = 1'b0;
        end else if (flush_en && r[5:0] == 6'd0) begin
            r        = next_rand();
            flush    = 1'b1;
            flush_pc = {r[31:2], 2'b00};
        end
        if (mr_state == 1) begin
            if (mr_cnt == 0) begin
                mem_ack    = 1'b1;
                mem_rdata0 = mem_word(mr_addr, priv_en);
                mem_rdata1 = mem_word(mr_addr + 32'd4, priv_en);
                mr_state   = 2;
            end else begin
                mr_cnt--;
            end
        end else if (mr_state == 3) begin
            if (mr_cnt == 0) begin
                mem_ack    = 1'b0;
                mem_rdata0 = next_rand();  // junk once ack is low
                mem_rdata1 = next_rand();
                mr_state   = 0;
            end else begin
                mr_cnt--;
            end
        end
        // any kind before execute, only the wrong kinds after it
        if (ser_phase != 0) begin
            r = next_rand();
            cache_idle = (ser_phase == 1 || ser_kind != 1) && (r[1:0] == 2'd0);
            csr_done   = (ser_phase == 1 || ser_kind != 2) && (r[3:2] == 2'd0);
            tlb_done   = (ser_phase == 1 || ser_kind != 3) && (r[5:4] == 2'd0);
        end
        if (ser_phase == 1) begin
            if (ser_cnt == 0) begin
                priv_at_ex = 1'b1;
                ser_phase  = 2;
                ser_cnt    = next_rand() % 8;
            end else begin
                ser_cnt--;
            end
        end else if (ser_phase == 2) begin
            if (ser_cnt == 0) begin
                case (ser_kind)
                    1:       cache_idle = 1'b1;
                    2:       csr_done = 1'b1;
                    default: tlb_done = 1'b1;
                endcase
                ser_phase = 0;
                blocked   = 1'b0;
            end else begin
                ser_cnt--;
            end
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        check_cycle();
        @(posedge clk);
        cycle_cnt++;
        #1;
        drive_cycle();
    endtask

    task automatic run_test(input int id, input string name, input int n, input logic p_en,
                            input logic b_en, input logic f_en, input logic [31:0] base);
        test_err   = 0;
        groups     = 0;
        serialized = 0;
        test_priv  = p_en;
        bp_en      = b_en;
        flush_en   = f_en;
        if (id > 1) begin
            flush_req    = 1'b1;  // each later test starts in a fresh region
            flush_target = base;
        end
        while (groups < n) run_cycle();
        $display("test %0d %s: %0d groups, %0d serialized, %0d errors",
                 id, name, groups, serialized, test_err);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        wait (cycle_limit > 0 && cycle_cnt >= cycle_limit);
        $display("timeout after %0d cycles, decode stopped receiving groups", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        arst_n       = 1'b0;
        flush        = 1'b0;
        flush_pc     = 32'd0;
        mem_ack      = 1'b0;
        mem_rdata0   = 32'd0;
        mem_rdata1   = 32'd0;
        dec_ready    = 1'b0;
        priv_at_ex   = 1'b0;
        cache_idle   = 1'b0;
        csr_done     = 1'b0;
        tlb_done     = 1'b0;
        rng          = 32'hd7d8;
        cycle_cnt    = 0;
        errors       = 0;
        exp_pc       = fetch_pkg::PC_RESET;
        priv_en      = 1'b0;
        test_priv    = 1'b0;
        flush_req    = 1'b0;
        flush_target = 32'd0;
        mr_state     = 0;
        mr_cnt       = 0;
        mr_addr      = 32'd0;
        prev_req     = 1'b0;
        prev_addr    = 32'd0;
        ser_phase    = 0;
        ser_kind     = 0;
        ser_cnt      = 0;
        blocked      = 1'b0;
        cycle_limit  = 40 * (40 + 60 + 60 + 60);  // 40 cycles per requested group
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        dec_ready = 1'b1;
        run_test(1, "sequential", 40, 1'b0, 1'b0, 1'b0, fetch_pkg::PC_RESET);
        run_test(2, "privileged", 60, 1'b1, 1'b0, 1'b0, 32'h1c00_4000);
        run_test(3, "back-pressure", 60, 1'b1, 1'b1, 1'b0, 32'h1c01_0000);
        run_test(4, "flush", 60, 1'b1, 1'b1, 1'b1, 32'h1c02_0000);
        $display("4 tests, %0d cycles, %0d errors", cycle_cnt, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // first fetch group after reset
    localparam logic [31:0] PC_RESET = 32'h1c00_0000;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // major opcodes, inst[31:22]
    localparam logic [9:0] OP_IBAR = 10'h0e1;  // instruction barrier
    localparam logic [9:0] OP_CSR  = 10'h010;  // csr read/write/exchange
    localparam logic [9:0] OP_TLB  = 10'h019;  // tlb search/read/write/flush

    // kind of privileged instruction found in a group
    typedef enum logic [1:0] {
        priv_none = 2'd0,
        priv_ibar = 2'd1,
        priv_csr  = 2'd2,
        priv_tlb  = 2'd3
    } priv_kind_t;

endpackage

`default_nettype wire

// File: source/fetch_skid_reg.sv
`default_nettype none

module fetch_skid_reg (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         flush,
    input  wire         in_valid,
    input  wire  [31:0] in_pc,
    input  wire  [31:0] in_inst0,
    input  wire  [31:0] in_inst1,
    input  wire         dec_ready,
    output logic        dec_valid,
    output logic [31:0] dec_pc,
    output logic [31:0] dec_inst0,
    output logic [31:0] dec_inst1,
    output logic        skid_free
);

    logic        skid_valid;
    logic [31:0] skid_pc;
    logic [31:0] skid_inst0;
    logic [31:0] skid_inst1;
    logic        main_take;   // main register free at next edge
    logic        load_main;
    logic        load_skid;

    assign main_take = !dec_valid || dec_ready;

    // skid entry is always older than a new input
    assign load_main = main_take && (skid_valid || in_valid);
    assign load_skid = in_valid && (skid_valid || !main_take);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (flush) begin
            dec_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_take) dec_valid <= skid_valid || in_valid;
            if (load_skid) begin
                skid_valid <= 1'b1;
            end else if (main_take) begin
                skid_valid <= 1'b0;  // promoted to main
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            dec_pc    <= skid_valid ? skid_pc : in_pc;
            dec_inst0 <= skid_valid ? skid_inst0 : in_inst0;
            dec_inst1 <= skid_valid ? skid_inst1 : in_inst1;
        end
        if (load_skid) begin
            skid_pc    <= in_pc;
            skid_inst0 <= in_inst0;
            skid_inst1 <= in_inst1;
        end
    end

    assign skid_free = !skid_valid;

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`default_nettype none

module fetch_top (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         flush,
    input  wire  [31:0] flush_pc,
    input  wire         mem_ack,
    input  wire  [31:0] mem_rdata0,
    input  wire  [31:0] mem_rdata1,
    input  wire         dec_ready,
    input  wire         priv_at_ex,
    input  wire         cache_idle,
    input  wire         csr_done,
    input  wire         tlb_done,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        dec_valid,
    output logic [31:0] dec_pc,
    output logic [31:0] dec_inst0,
    output logic [31:0] dec_inst1
);

    logic [31:0]           fetch_pc;
    logic                  fetch_hold;
    logic                  skid_free;
    logic                  grp_valid;
    logic [31:0]           grp_pc;
    logic [31:0]           grp_inst0;
    logic [31:0]           grp_inst1;
    logic [31:0]           out_inst1;
    fetch_pkg::priv_kind_t pkind;
    logic                  pslot1;
    logic [31:0]           grp_next_pc;
    logic                  restart_valid;
    logic [31:0]           restart_pc;

    pc_gen u_pc_gen (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .flush_pc      (flush_pc),
        .fetch_adv     (grp_valid),
        .adv_pc        (grp_next_pc),
        .restart_valid (restart_valid),
        .restart_pc    (restart_pc),
        .fetch_pc      (fetch_pc)
    );

    imem_fetch_port u_fetch_port (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .fetch_pc   (fetch_pc),
        .fetch_hold (fetch_hold),
        .skid_free  (skid_free),
        .mem_ack    (mem_ack),
        .mem_rdata0 (mem_rdata0),
        .mem_rdata1 (mem_rdata1),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .grp_valid  (grp_valid),
        .grp_pc     (grp_pc),
        .grp_inst0  (grp_inst0),
        .grp_inst1  (grp_inst1)
    );

    priv_predecode u_predecode (
        .grp_pc      (grp_pc),
        .grp_inst0   (grp_inst0),
        .grp_inst1   (grp_inst1),
        .out_inst1   (out_inst1),
        .pkind       (pkind),
        .pslot1      (pslot1),
        .grp_next_pc (grp_next_pc)
    );

    priv_serializer u_serializer (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .grp_valid     (grp_valid),
        .grp_pc        (grp_pc),
        .pkind         (pkind),
        .pslot1        (pslot1),
        .priv_at_ex    (priv_at_ex),
        .cache_idle    (cache_idle),
        .csr_done      (csr_done),
        .tlb_done      (tlb_done),
        .fetch_hold    (fetch_hold),
        .restart_valid (restart_valid),
        .restart_pc    (restart_pc)
    );

    // predecoded group goes straight to the stage register
    fetch_skid_reg u_skid_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (grp_valid),
        .in_pc     (grp_pc),
        .in_inst0  (grp_inst0),
        .in_inst1  (out_inst1),
        .dec_ready (dec_ready),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_inst0 (dec_inst0),
        .dec_inst1 (dec_inst1),
        .skid_free (skid_free)
    );

endmodule

`default_nettype wire

// File: source/imem_fetch_port.sv
`default_nettype none

module imem_fetch_port (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         flush,
    input  wire  [31:0] fetch_pc,
    input  wire         fetch_hold,
    input  wire         skid_free,
    input  wire         mem_ack,
    input  wire  [31:0] mem_rdata0,
    input  wire  [31:0] mem_rdata1,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        grp_valid,
    output logic [31:0] grp_pc,
    output logic [31:0] grp_inst0,
    output logic [31:0] grp_inst1
);

    typedef enum logic [1:0] {
        idle     = 2'd0,
        wait_ack = 2'd1,
        wait_rel = 2'd2
    } port_state_t;

    port_state_t state;
    logic        stale;     // flushed while in flight
    logic [31:0] req_addr;
    logic        start;

    // a flush in the same cycle would issue the old pc
    assign start = (state == idle) && !fetch_hold && skid_free && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= idle;
            mem_req <= 1'b0;
            stale   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state   <= wait_ack;
                        mem_req <= 1'b1;
                        stale   <= 1'b0;
                    end
                end
                wait_ack: begin
                    if (mem_ack) begin
                        state   <= wait_rel;
                        mem_req <= 1'b0;
                    end else if (flush) begin
                        stale <= 1'b1;
                    end
                end
                default: begin
                    if (!mem_ack) state <= idle;  // four-phase release
                end
            endcase
        end
    end

    // address held for the whole handshake
    always_ff @(posedge clk) begin
        if (start) req_addr <= fetch_pc;
    end

    assign mem_addr = req_addr;

    // memory holds data while ack is high, so pass it straight through
    assign grp_valid = (state == wait_ack) && mem_ack && !stale && !flush;
    assign grp_pc    = req_addr;
    assign grp_inst0 = mem_rdata0;
    assign grp_inst1 = mem_rdata1;

endmodule

`default_nettype wire

// File: source/pc_gen.sv
`default_nettype none

module pc_gen (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         flush,
    input  wire  [31:0] flush_pc,
    input  wire         fetch_adv,
    input  wire  [31:0] adv_pc,
    input  wire         restart_valid,
    input  wire  [31:0] restart_pc,
    output logic [31:0] fetch_pc
);

    // flush beats restart beats sequential advance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= fetch_pkg::PC_RESET;
        end else if (flush) begin
            fetch_pc <= flush_pc;
        end else if (restart_valid) begin
            fetch_pc <= restart_pc;  // resume after privileged inst
        end else if (fetch_adv) begin
            fetch_pc <= adv_pc;      // +4 or +8 from predecode
        end
    end

endmodule

`default_nettype wire

// File: source/priv_predecode.sv
`default_nettype none

module priv_predecode (
    input  wire         [31:0] grp_pc,
    input  wire         [31:0] grp_inst0,
    input  wire         [31:0] grp_inst1,
    output logic        [31:0] out_inst1,
    output fetch_pkg::priv_kind_t pkind,
    output logic               pslot1,
    output logic        [31:0] grp_next_pc
);

    fetch_pkg::priv_kind_t kind0;
    fetch_pkg::priv_kind_t kind1;
    logic                  priv0;

    function automatic fetch_pkg::priv_kind_t classify(input logic [31:0] inst);
        case (inst[31:22])
            fetch_pkg::OP_IBAR: return fetch_pkg::priv_ibar;
            fetch_pkg::OP_CSR:  return fetch_pkg::priv_csr;
            fetch_pkg::OP_TLB:  return fetch_pkg::priv_tlb;
            default:            return fetch_pkg::priv_none;
        endcase
    endfunction

    assign kind0 = classify(grp_inst0);
    assign kind1 = classify(grp_inst1);
    assign priv0 = (kind0 != fetch_pkg::priv_none);

    // slot 0 wins, slot 1 is squashed behind it
    assign pkind       = priv0 ? kind0 : kind1;
    assign pslot1      = !priv0 && (kind1 != fetch_pkg::priv_none);
    assign out_inst1   = priv0 ? fetch_pkg::INST_NOP : grp_inst1;
    assign grp_next_pc = grp_pc + (priv0 ? 32'd4 : 32'd8);

endmodule

`default_nettype wire

// File: source/priv_serializer.sv
`default_nettype none

module priv_serializer (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   flush,
    input  wire                   grp_valid,
    input  wire            [31:0] grp_pc,
    input  wire fetch_pkg::priv_kind_t pkind,
    input  wire                   pslot1,
    input  wire                   priv_at_ex,
    input  wire                   cache_idle,
    input  wire                   csr_done,
    input  wire                   tlb_done,
    output logic                  fetch_hold,
    output logic                  restart_valid,
    output logic           [31:0] restart_pc
);

    typedef enum logic [2:0] {
        idle       = 3'd0,
        wait_ex    = 3'd1,
        wait_cache = 3'd2,
        wait_csr   = 3'd3,
        wait_tlb   = 3'd4,
        restart    = 3'd5
    } ser_state_t;

    ser_state_t            state;
    fetch_pkg::priv_kind_t kind_q;
    logic                  capture;

    assign capture = (state == idle) && grp_valid && (pkind != fetch_pkg::priv_none);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= idle;
            kind_q <= fetch_pkg::priv_none;
        end else if (flush) begin
            state  <= idle;
            kind_q <= fetch_pkg::priv_none;
        end else begin
            case (state)
                idle: begin
                    if (capture) begin
                        state  <= wait_ex;
                        kind_q <= pkind;
                    end
                end
                wait_ex: begin
                    if (priv_at_ex) begin
                        case (kind_q)
                            fetch_pkg::priv_ibar: state <= wait_cache;
                            fetch_pkg::priv_csr:  state <= wait_csr;
                            default:              state <= wait_tlb;
                        endcase
                    end
                end
                wait_cache: if (cache_idle) state <= restart;
                wait_csr:   if (csr_done) state <= restart;
                wait_tlb:   if (tlb_done) state <= restart;
                default:    state <= idle;  // restart lasts one cycle
            endcase
        end
    end

    // instruction after the privileged one
    always_ff @(posedge clk) begin
        if (capture) restart_pc <= grp_pc + (pslot1 ? 32'd8 : 32'd4);
    end

    // hold also covers the capture cycle and the restart cycle itself
    assign fetch_hold    = (state != idle) || capture;
    assign restart_valid = (state == restart);

endmodule

`default_nettype wire
